/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module tb_single_cycle_core
	verilator --lint-only hw/cpu_types_pkg.sv hw/alu.sv hw/control_unit.sv \
		hw/register_file.sv hw/pc_unit.sv hw/single_cycle_core.sv \
		--top-module single_cycle_core

sim:
	verilator --binary --timing --assert -j 0 -f build.f \
		--top-module tb_single_cycle_core -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_single_cycle_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+tb
hw/cpu_types_pkg.sv
hw/alu.sv
hw/control_unit.sv
hw/register_file.sv
hw/pc_unit.sv
hw/single_cycle_core.sv
tb/tb_single_cycle_core.sv

/* hw/alu.sv */
// Shift amount is portb[4:0] applied to porta; no overflow detection for ADD or SUB
`timescale 1ns/100ps

module alu
	import cpu_types_pkg::*;
(
	input  word_t  porta,
	input  word_t  portb,
	input  aluop_t alu_op,
	output word_t  result,
	output logic   zero
);

	logic [4:0] shift_amt;

	assign shift_amt = portb[4:0];

	always_comb
	begin
		case (alu_op)
			ALU_SLL: result = porta << shift_amt;
			ALU_SRL: result = porta >> shift_amt;
			ALU_ADD: result = porta + portb;
			ALU_SUB: result = porta - portb;
			ALU_AND: result = porta & portb;
			ALU_OR: result = porta | portb;
			ALU_XOR: result = porta ^ portb;
			ALU_NOR: result = ~(porta | portb);
			// Set-less-than results are 1 or 0
			ALU_SLT: result = ($signed(porta) < $signed(portb)) ? 32'd1 : 32'd0;
			ALU_SLTU: result = (porta < portb) ? 32'd1 : 32'd0;
			default: result = '0;
		endcase
	end

	// Used for BEQ and BNE
	assign zero = (result == '0);

endmodule

/* hw/control_unit.sv */
// Purely combinational; unknown opcodes or functs give an unknown alu_op, and branches resolve here
`timescale 1ns/100ps

module control_unit
	import cpu_types_pkg::*;
(
	input  word_t      instr,
	input  logic       alu_zero,
	output aluop_t     alu_op,
	output pc_sel_t    pc_sel,
	output portb_sel_t portb_sel,
	output wdata_sel_t wdata_sel,
	output regw_sel_t  regw_sel,
	output logic       porta_sel,
	output logic       imm_ext_sel,
	output logic       mem_ren,
	output logic       mem_wen,
	output logic       reg_wen,
	output logic       halt_instr
);

	r_t rinstr;
	i_t iinstr;
	j_t jinstr;
	logic is_jr;

	assign rinstr = r_t'(instr);
	assign iinstr = i_t'(instr);
	assign jinstr = j_t'(instr);

	assign is_jr = (rinstr.opcode == RTYPE) && (rinstr.funct == JR);

	always_comb
	begin
		halt_instr = (iinstr.opcode == HALT);
		mem_ren = (iinstr.opcode == LW);
		mem_wen = (iinstr.opcode == SW);
		// LUI routes the immediate through port A
		porta_sel = (iinstr.opcode == LUI);

		// Sign extend for arithmetic, memory and branch immediates
		case (iinstr.opcode)
			ADDI, ADDIU, SLTI, SLTIU, LW, SW, BEQ, BNE: imm_ext_sel = 1'b1;
			default: imm_ext_sel = 1'b0;
		endcase

		if (iinstr.opcode == RTYPE)
			portb_sel = (rinstr.funct == SLL || rinstr.funct == SRL) ? PB_SHAMT : PB_RT;
		else if (iinstr.opcode == BEQ || iinstr.opcode == BNE)
			portb_sel = PB_RT;
		else if (iinstr.opcode == LUI)
			portb_sel = PB_SIXTEEN;
		else
			portb_sel = PB_IMM;

		if (iinstr.opcode == LW)
			wdata_sel = WD_MEM;
		else if (jinstr.opcode == JAL)
			wdata_sel = WD_PC4;
		else
			wdata_sel = WD_ALU;

		if (jinstr.opcode == JAL)
			regw_sel = RW_RA;
		else if (rinstr.opcode == RTYPE)
			regw_sel = RW_RD;
		else
			regw_sel = RW_RT;

		// SLL into r0 is the NOP encoding
		reg_wen = !(is_jr ||
			(rinstr.opcode == RTYPE && rinstr.funct == SLL && rinstr.rd == 5'd0) ||
			iinstr.opcode == BEQ || iinstr.opcode == BNE ||
			iinstr.opcode == SW || jinstr.opcode == J);

		// Next PC, branch condition from the subtract result
		if (is_jr)
			pc_sel = PC_REG;
		else if ((iinstr.opcode == BEQ && alu_zero) || (iinstr.opcode == BNE && !alu_zero))
			pc_sel = PC_BRANCH;
		else if (jinstr.opcode == J || jinstr.opcode == JAL)
			pc_sel = PC_JUMP;
		else
			pc_sel = PC_NEXT;
	end

	always_comb
	begin
		if (rinstr.opcode == RTYPE)
		begin
			case (rinstr.funct)
				SLL: alu_op = ALU_SLL;
				SRL: alu_op = ALU_SRL;
				ADD, ADDU: alu_op = ALU_ADD;
				SUB, SUBU: alu_op = ALU_SUB;
				AND: alu_op = ALU_AND;
				OR: alu_op = ALU_OR;
				XOR: alu_op = ALU_XOR;
				NOR: alu_op = ALU_NOR;
				SLT: alu_op = ALU_SLT;
				SLTU: alu_op = ALU_SLTU;
				default: alu_op = aluop_t'('x);
			endcase
		end
		else
		begin
			case (iinstr.opcode)
				ADDI, ADDIU, LW, SW, JAL, HALT: alu_op = ALU_ADD;
				LUI: alu_op = ALU_SLL;
				ANDI: alu_op = ALU_AND;
				ORI: alu_op = ALU_OR;
				XORI: alu_op = ALU_XOR;
				BEQ, BNE: alu_op = ALU_SUB;
				SLTI: alu_op = ALU_SLT;
				SLTIU: alu_op = ALU_SLTU;
				default: alu_op = aluop_t'('x);
			endcase
		end
	end

	// Sampled on each instruction change, so the outgoing decode is checked
	a_op_known: assert property (@(instr) (reg_wen || mem_wen) |-> !$isunknown(alu_op));

endmodule

/* hw/cpu_types_pkg.sv */
// MIPS-like encodings only; no coprocessor, multiply/divide or exception opcodes are defined
package cpu_types_pkg;

	typedef logic [31:0] word_t;

	// Primary opcodes, standard MIPS values plus HALT
	typedef enum logic [5:0]
	{
		RTYPE = 6'h00,
		J     = 6'h02,
		JAL   = 6'h03,
		BEQ   = 6'h04,
		BNE   = 6'h05,
		ADDI  = 6'h08,
		ADDIU = 6'h09,
		SLTI  = 6'h0a,
		SLTIU = 6'h0b,
		ANDI  = 6'h0c,
		ORI   = 6'h0d,
		XORI  = 6'h0e,
		LUI   = 6'h0f,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} opcode_t;

	// R-type function codes
	typedef enum logic [5:0]
	{
		SLL  = 6'h00,
		SRL  = 6'h02,
		JR   = 6'h08,
		ADD  = 6'h20,
		ADDU = 6'h21,
		SUB  = 6'h22,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} funct_t;

	// Instruction formats
	typedef struct packed
	{
		opcode_t opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t funct;
	} r_t;

	typedef struct packed
	{
		opcode_t opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_t;

	typedef struct packed
	{
		opcode_t opcode;
		logic [25:0] addr;
	} j_t;

	typedef enum logic [3:0]
	{
		ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND,
		ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
	} aluop_t;

	// Datapath select encodings
	typedef enum logic [1:0] {PC_NEXT, PC_REG, PC_JUMP, PC_BRANCH} pc_sel_t;
	typedef enum logic [1:0] {PB_RT, PB_SHAMT, PB_IMM, PB_SIXTEEN} portb_sel_t;
	typedef enum logic [1:0] {WD_ALU, WD_MEM, WD_PC4} wdata_sel_t;
	typedef enum logic [1:0] {RW_RD, RW_RT, RW_RA} regw_sel_t;

endpackage

/* hw/pc_unit.sv */
// RESET_PC must be word-aligned; JR to a misaligned register value is flagged, not trapped
`timescale 1ns/100ps

module pc_unit
	import cpu_types_pkg::*;
#(
	parameter word_t RESET_PC = '0
)
(
	input  logic        clk,
	input  logic        reset,
	input  logic        hold,
	input  pc_sel_t     pc_sel,
	input  word_t       reg_target,
	input  word_t       imm_ext,
	input  logic [25:0] jump_index,
	output word_t       pc,
	output word_t       pc_plus4
);

	word_t next_pc;

	assign pc_plus4 = pc + 32'd4;

	always_comb
	begin
		case (pc_sel)
			PC_REG: next_pc = reg_target;
			// Region-relative jump inside the current 256 MB block
			PC_JUMP: next_pc = {pc_plus4[31:28], jump_index, 2'b00};
			PC_BRANCH: next_pc = pc_plus4 + {imm_ext[29:0], 2'b00};
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else if (!hold)
			pc <= next_pc;
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* hw/register_file.sv */
// Writes land at the clock edge and reads have no bypass, so a write is visible next cycle
`timescale 1ns/100ps

module register_file
	import cpu_types_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic [4:0] rs_addr,
	input  logic [4:0] rt_addr,
	input  logic [4:0] w_addr,
	input  logic       wen,
	input  word_t      wdata,
	output word_t      rs_data,
	output word_t      rt_data
);

	// No storage behind r0
	word_t regs [1:31];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wen && w_addr != 5'd0)
			regs[w_addr] <= wdata;
	end

	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

/* hw/single_cycle_core.sv */
// Both memory ports must answer combinationally; once HALT is fetched only reset restarts the core
`timescale 1ns/100ps

module single_cycle_core
	import cpu_types_pkg::*;
#(
	parameter word_t RESET_PC = '0
)
(
	input  logic  clk,
	input  logic  reset,
	output word_t imem_addr,
	input  word_t imem_rdata,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic  dmem_ren,
	output logic  dmem_wen,
	input  word_t dmem_rdata,
	output logic  halt
);

	r_t rinstr;
	j_t jinstr;
	aluop_t alu_op;
	pc_sel_t pc_sel;
	portb_sel_t portb_sel;
	wdata_sel_t wdata_sel;
	regw_sel_t regw_sel;
	logic porta_sel, imm_ext_sel, mem_ren, mem_wen, reg_wen, halt_instr;
	logic alu_zero, halted;
	logic [4:0] w_addr;
	word_t imm_ext, porta, portb, alu_result, rs_data, rt_data, wdata, pc, pc_plus4;

	assign rinstr = r_t'(imem_rdata);
	assign jinstr = j_t'(imem_rdata);

	control_unit i_control_unit (
		.instr(imem_rdata), .alu_zero(alu_zero), .alu_op(alu_op), .pc_sel(pc_sel),
		.portb_sel(portb_sel), .wdata_sel(wdata_sel), .regw_sel(regw_sel),
		.porta_sel(porta_sel), .imm_ext_sel(imm_ext_sel), .mem_ren(mem_ren),
		.mem_wen(mem_wen), .reg_wen(reg_wen), .halt_instr(halt_instr)
	);

	// Immediate sits in the low half of the word
	assign imm_ext = imm_ext_sel ? {{16{imem_rdata[15]}}, imem_rdata[15:0]}
		: {16'h0000, imem_rdata[15:0]};

	assign porta = porta_sel ? imm_ext : rs_data;

	always_comb
	begin
		case (portb_sel)
			PB_SHAMT: portb = {27'd0, rinstr.shamt};
			PB_IMM: portb = imm_ext;
			PB_SIXTEEN: portb = 32'd16;
			default: portb = rt_data;
		endcase
		case (wdata_sel)
			WD_MEM: wdata = dmem_rdata;
			WD_PC4: wdata = pc_plus4;
			default: wdata = alu_result;
		endcase
		case (regw_sel)
			RW_RD: w_addr = rinstr.rd;
			RW_RA: w_addr = 5'd31;
			default: w_addr = rinstr.rt;
		endcase
	end

	alu i_alu (
		.porta(porta), .portb(portb), .alu_op(alu_op), .result(alu_result), .zero(alu_zero)
	);

	register_file i_register_file (
		.clk(clk), .reset(reset), .rs_addr(rinstr.rs), .rt_addr(rinstr.rt), .w_addr(w_addr),
		.wen(reg_wen && !halt), .wdata(wdata), .rs_data(rs_data), .rt_data(rt_data)
	);

	pc_unit #(.RESET_PC(RESET_PC)) i_pc_unit (
		.clk(clk), .reset(reset), .hold(halt), .pc_sel(pc_sel), .reg_target(rs_data),
		.imm_ext(imm_ext), .jump_index(jinstr.addr), .pc(pc), .pc_plus4(pc_plus4)
	);

	// Sticky until reset
	always_ff @(posedge clk)
	begin
		if (reset)
			halted <= 1'b0;
		else if (halt_instr)
			halted <= 1'b1;
	end

	assign halt = halt_instr || halted;
	assign imem_addr = pc;
	assign dmem_addr = alu_result;
	assign dmem_wdata = rt_data;
	assign dmem_ren = mem_ren && !halted && !reset;
	assign dmem_wen = mem_wen && !halted && !reset;

endmodule

/* tb/tb_program.svh */
// Program starts at address zero and must run its stores in table order; shifts take rs as source

localparam int PROG_LEN = 53;
localparam int STORE_COUNT = 19;
// One LW in the program
localparam int LOAD_COUNT = 1;
// HALT sits at word 47
localparam word_t HALT_PC = 32'h0000_00bc;

localparam word_t PROGRAM [PROG_LEN] = '{
	// Operands r1 = -10, r2 = 7
	{ADDI, 5'd0, 5'd1, 16'hfff6}, {ORI, 5'd0, 5'd2, 16'h0007},
	// R-type results, each stored
	{RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, ADDU}, {SW, 5'd0, 5'd3, 16'h0000},
	{RTYPE, 5'd2, 5'd1, 5'd4, 5'd0, SUBU}, {SW, 5'd0, 5'd4, 16'h0004},
	{RTYPE, 5'd1, 5'd2, 5'd5, 5'd0, AND}, {SW, 5'd0, 5'd5, 16'h0008},
	{RTYPE, 5'd1, 5'd2, 5'd6, 5'd0, OR}, {SW, 5'd0, 5'd6, 16'h000c},
	{RTYPE, 5'd1, 5'd2, 5'd7, 5'd0, XOR}, {SW, 5'd0, 5'd7, 16'h0010},
	{RTYPE, 5'd1, 5'd2, 5'd8, 5'd0, NOR}, {SW, 5'd0, 5'd8, 16'h0014},
	{RTYPE, 5'd1, 5'd2, 5'd9, 5'd0, SLT}, {SW, 5'd0, 5'd9, 16'h0018},
	{RTYPE, 5'd1, 5'd2, 5'd10, 5'd0, SLTU}, {SW, 5'd0, 5'd10, 16'h001c},
	// Zero extension, LUI, shifts by shamt
	{ORI, 5'd0, 5'd11, 16'hfff0}, {SW, 5'd0, 5'd11, 16'h0020},
	{ANDI, 5'd1, 5'd12, 16'h8ff6}, {SW, 5'd0, 5'd12, 16'h0024},
	{LUI, 5'd0, 5'd13, 16'h1234}, {SW, 5'd0, 5'd13, 16'h0028},
	{RTYPE, 5'd2, 5'd0, 5'd14, 5'd4, SLL}, {SW, 5'd0, 5'd14, 16'h002c},
	{RTYPE, 5'd3, 5'd0, 5'd15, 5'd8, SRL}, {SW, 5'd0, 5'd15, 16'h0030},
	// Store, load back, add
	{SW, 5'd0, 5'd2, 16'h0034}, {LW, 5'd0, 5'd16, 16'h0034},
	{RTYPE, 5'd16, 5'd4, 5'd17, 5'd0, ADDU}, {SW, 5'd0, 5'd17, 16'h0038},
	// BEQ taken over poison, BNE falls through to a marker
	{BEQ, 5'd2, 5'd16, 16'h0001}, {SW, 5'd0, 5'd1, 16'h003c},
	{BNE, 5'd2, 5'd16, 16'h0001}, {ORI, 5'd0, 5'd18, 16'h00b1},
	{SW, 5'd0, 5'd18, 16'h0040},
	// BNE taken over poison, BEQ falls through
	{BNE, 5'd2, 5'd4, 16'h0001}, {SW, 5'd0, 5'd1, 16'h0044},
	{BEQ, 5'd2, 5'd4, 16'h0001}, {ORI, 5'd0, 5'd19, 16'h00b2},
	{SW, 5'd0, 5'd19, 16'h0044},
	// J over two poison stores, call, store of r31, HALT, dead store
	{J, 26'd45}, {SW, 5'd0, 5'd1, 16'h0048},
	{SW, 5'd0, 5'd1, 16'h0048}, {JAL, 26'd49},
	{SW, 5'd0, 5'd31, 16'h004c}, {HALT, 26'd0},
	{SW, 5'd0, 5'd1, 16'h0050},
	// Subroutine at word 49
	{ORI, 5'd0, 5'd20, 16'h00c3}, {SW, 5'd0, 5'd20, 16'h0048},
	{RTYPE, 5'd31, 5'd0, 5'd0, 5'd0, JR}, {SW, 5'd0, 5'd1, 16'h0054}
};

// Address in the upper half, data in the lower half
localparam logic [63:0] STORES [STORE_COUNT] = '{
	64'h00000000_fffffffd, 64'h00000004_00000011, 64'h00000008_00000006,
	64'h0000000c_fffffff7, 64'h00000010_fffffff1, 64'h00000014_00000008,
	64'h00000018_00000001, 64'h0000001c_00000000, 64'h00000020_0000fff0,
	64'h00000024_00008ff6, 64'h00000028_12340000, 64'h0000002c_00000070,
	64'h00000030_00ffffff, 64'h00000034_00000007, 64'h00000038_00000018,
	64'h00000040_000000b1, 64'h00000044_000000b2, 64'h00000048_000000c3,
	64'h0000004c_000000b8
};

/* tb/tb_single_cycle_core.sv */
// Data RAM covers 64 words from address zero; stores must appear in exactly the table order
`timescale 1ns/100ps

module tb_single_cycle_core
	import cpu_types_pkg::*;
();

	`include "tb_program.svh"

	logic clk;
	logic reset;
	word_t imem_addr;
	word_t imem_rdata;
	word_t dmem_addr;
	word_t dmem_wdata;
	word_t dmem_rdata;
	logic dmem_ren;
	logic dmem_wen;
	logic halt;
	word_t ram [64];
	int load_count = 0;

	single_cycle_core #(.RESET_PC(32'h0)) i_dut (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_ren(dmem_ren),
		.dmem_wen(dmem_wen),
		.dmem_rdata(dmem_rdata),
		.halt(halt)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Instruction ROM, words past the program read as HALT
	assign imem_rdata = (imem_addr[31:2] < PROG_LEN) ? PROGRAM[imem_addr[7:2]] : {HALT, 26'd0};

	// Data RAM, combinational read while the load enable is high
	assign dmem_rdata = dmem_ren ? ram[dmem_addr[7:2]] : 32'hdead_beef;

	always @(posedge clk)
	begin
		if (dmem_wen)
			ram[dmem_addr[7:2]] <= dmem_wdata;
	end

	// Load cycles, counted where the decode is settled
	always @(negedge clk)
	begin
		if (dmem_ren)
			load_count = load_count + 1;
	end

	task automatic check_value(input string what, input word_t actual, input word_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timed out after 200 cycles waiting for %s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	endtask

	// Samples at the falling edge, where the decode is settled
	task automatic wait_for_store(input int index);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!dmem_wen && cycles < 200)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!dmem_wen)
			stop_on_timeout($sformatf("store %0d", index));
	endtask

	initial
	begin
		word_t held_pc;
		int cycles;
		reset <= 1'b1;
		for (int i = 0; i < 64; i++)
			ram[i] <= 32'hc0de0000 | i;

		repeat (16) @(posedge clk);
		reset <= 1'b0;

		for (int s = 0; s < STORE_COUNT; s++)
		begin
			wait_for_store(s);
			check_value($sformatf("store %0d address", s), dmem_addr, STORES[s][63:32]);
			check_value($sformatf("store %0d data", s), dmem_wdata, STORES[s][31:0]);
			// Let the store retire
			@(posedge clk);
		end

		cycles = 0;
		@(negedge clk);
		while (!halt && cycles < 200)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!halt)
			stop_on_timeout("halt");
		check_value("PC at halt", imem_addr, HALT_PC);

		// Core must stay frozen with no writes
		held_pc = imem_addr;
		repeat (10)
		begin
			@(negedge clk);
			check_value("store enable after halt", {31'd0, dmem_wen}, 32'd0);
			check_value("load enable after halt", {31'd0, dmem_ren}, 32'd0);
			check_value("PC after halt", imem_addr, held_pc);
			check_value("halt level", {31'd0, halt}, 32'd1);
		end
		check_value("load count", load_count, LOAD_COUNT);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
